//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/icache_ctrl.sv
      - design/icache_beat_counter.sv
      - design/icache_way.sv
      - design/icache_dp.sv
      - design/icache_top.sv
  - target: test
    files:
      - verification/wb_mem_model.sv
      - verification/icache_tb.sv

//--- design/icache_beat_counter.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_beat_counter (
	input  logic                               clk,
	input  logic                               reset,
	input  icache_pkg::count_op_t              count_op,
	output logic [$clog2(`ICACHE_WORDS)-1:0]   count_value,
	output logic                               count_last
);
	import icache_pkg::*;

	localparam int CW = $clog2(`ICACHE_WORDS);
	localparam logic [CW-1:0] LAST = CW'(`ICACHE_WORDS - 1);

	// refill beat number or set index while flushing
	always_ff @(posedge clk) begin
		if (reset) begin
			count_value <= '0;
		end else begin
			case (count_op)
				CNT_CLEAR: count_value <= '0;
				CNT_STEP:  count_value <= count_value + 1'b1;
				default:   count_value <= count_value;
			endcase
		end
	end

	assign count_last = (count_value == LAST);

endmodule

`default_nettype wire

//--- design/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry for a 32-bit address

// byte offset inside one 32-byte line
`define ICACHE_OFFSET_BITS 5

// eight sets per way
`define ICACHE_INDEX_BITS 3

// what is left of the address above index and offset
`define ICACHE_TAG_BITS 24

// words per line and the number of sets walked by a flush
`define ICACHE_WORDS 8

`endif

//--- design/icache_ctrl.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  flush,
	input  logic                  s2_valid,
	input  logic                  hit,
	input  logic                  count_last,
	input  logic                  wb_ack,
	output logic                  idle_ready,
	output icache_pkg::count_op_t count_op,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic                  beat_take,
	output logic                  fill_write,
	output logic                  respond,
	output logic                  flush_clear
);
	import icache_pkg::*;

	icache_state_t state;
	icache_state_t state_next;
	logic          flush_take;

	// flush only starts with stage 2 empty
	assign flush_take = flush && !s2_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			// walk all sets once so valid and lru start clean
			state <= ST_FLUSH;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next  = state;
		idle_ready  = 1'b0;
		count_op    = CNT_CLEAR;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		beat_take   = 1'b0;
		fill_write  = 1'b0;
		respond     = 1'b0;
		flush_clear = 1'b0;

		case (state)
			ST_IDLE: begin
				// no new request on the edge that takes a flush
				idle_ready = !flush_take;
				if (flush_take) begin
					state_next = ST_FLUSH;
				end else if (s2_valid && !hit) begin
					state_next = ST_REFILL;
				end
			end

			ST_REFILL: begin
				wb_cyc    = 1'b1;
				wb_stb    = 1'b1;
				beat_take = wb_ack;
				if (wb_ack && count_last) begin
					// park on the last beat so it marks the write cycle
					count_op   = CNT_HOLD;
					state_next = ST_RESPOND;
				end else if (wb_ack) begin
					count_op = CNT_STEP;
				end else begin
					count_op = CNT_HOLD;
				end
			end

			ST_RESPOND: begin
				// first cycle writes the line and the second returns the word
				if (count_last) begin
					fill_write = 1'b1;
				end else begin
					respond    = 1'b1;
					state_next = ST_IDLE;
				end
			end

			ST_FLUSH: begin
				flush_clear = 1'b1;
				if (count_last) begin
					state_next = ST_IDLE;
				end else begin
					count_op = CNT_STEP;
				end
			end

			default: state_next = ST_IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- design/icache_dp.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_dp (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cpu_req,
	input  logic [31:0]                        cpu_addr,
	input  logic                               idle_ready,
	input  logic                               beat_take,
	input  logic                               fill_write,
	input  logic                               respond,
	input  logic                               flush_clear,
	input  logic [$clog2(`ICACHE_WORDS)-1:0]   count_value,
	input  logic [31:0]                        wb_dat_i,
	output logic                               cpu_ready,
	output logic                               cpu_rvalid,
	output logic [31:0]                        cpu_rdata,
	output logic [31:0]                        wb_adr,
	output logic                               s2_valid,
	output logic                               hit
);
	localparam int IDX_LSB = `ICACHE_OFFSET_BITS;
	localparam int TAG_LSB = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;
	localparam int SETS    = 2 ** `ICACHE_INDEX_BITS;

	logic                                  accept;
	logic [31:0]                           s2_addr;
	logic [`ICACHE_TAG_BITS-1:0]           s2_tag;
	logic [`ICACHE_INDEX_BITS-1:0]         s2_index;
	logic [$clog2(`ICACHE_WORDS)-1:0]      s2_word;
	logic [`ICACHE_INDEX_BITS-1:0]         rindex;
	logic [`ICACHE_INDEX_BITS-1:0]         windex;
	logic [SETS-1:0]                       lru;
	logic                                  victim;
	logic [1:0]                            way_write;
	logic [1:0]                            way_hit;
	logic [1:0]                            way_valid;
	logic [`ICACHE_TAG_BITS-1:0]           way_tag  [2];
	logic [`ICACHE_WORDS-1:0][31:0]        way_line [2];
	logic [`ICACHE_WORDS-1:0][31:0]        hit_line;
	logic [`ICACHE_WORDS-1:0][31:0]        line_buf;

	// a stage-2 miss holds off the next request
	assign cpu_ready = idle_ready && !(s2_valid && !hit);
	assign accept    = cpu_req && cpu_ready;

	assign s2_tag   = s2_addr[31:TAG_LSB];
	assign s2_index = s2_addr[TAG_LSB-1:IDX_LSB];
	assign s2_word  = s2_addr[IDX_LSB-1:2];

	// keep re-reading the stage-2 set while nothing new comes in
	assign rindex = accept ? cpu_addr[TAG_LSB-1:IDX_LSB] : s2_index;
	assign windex = flush_clear ? count_value : s2_index;

	// lru bit names the way to replace next
	assign victim = lru[s2_index];

	for (genvar w = 0; w < 2; w++) begin : g_way
		icache_way u_way (
			.clk         (clk),
			.reset       (reset),
			.rindex      (rindex),
			.windex      (windex),
			.write       (way_write[w]),
			.flush_clear (flush_clear),
			.tag_in      (s2_tag),
			.line_in     (line_buf),
			.tag_out     (way_tag[w]),
			.valid_out   (way_valid[w]),
			.line_out    (way_line[w])
		);

		assign way_write[w] = fill_write && (victim == 1'(w));
		assign way_hit[w]   = way_valid[w] && (way_tag[w] == s2_tag);
	end

	assign hit = s2_valid && (|way_hit);

	// stage 2 request
	always_ff @(posedge clk) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else if (accept) begin
			s2_valid <= 1'b1;
		end else if (hit || respond) begin
			s2_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s2_addr <= cpu_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lru <= '0;
		end else if (flush_clear) begin
			lru[count_value] <= 1'b0;
		end else if (fill_write) begin
			lru[s2_index] <= ~victim;
		end else if (hit) begin
			// way 0 hit means way 1 goes next
			lru[s2_index] <= way_hit[0];
		end
	end

	// refill beats collect here until the line is written
	always_ff @(posedge clk) begin
		if (beat_take) begin
			line_buf[count_value] <= wb_dat_i;
		end
	end

	assign wb_adr = {s2_tag, s2_index, count_value, 2'b00};

	assign hit_line   = way_hit[1] ? way_line[1] : way_line[0];
	assign cpu_rdata  = respond ? line_buf[s2_word] : hit_line[s2_word];
	assign cpu_rvalid = hit || respond;

endmodule

`default_nettype wire

//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REFILL,
		ST_RESPOND,
		ST_FLUSH
	} icache_state_t;

	// beat / flush counter opcodes
	typedef enum logic [1:0] {
		CNT_HOLD,
		CNT_CLEAR,
		CNT_STEP
	} count_op_t;

endpackage

`default_nettype wire

//--- design/icache_top.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        flush,
	input  logic        cpu_req,
	input  logic [31:0] cpu_addr,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack,
	output logic        cpu_ready,
	output logic        cpu_rvalid,
	output logic [31:0] cpu_rdata,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic [31:0] wb_adr
);
	import icache_pkg::*;

	count_op_t                        count_op;
	logic [$clog2(`ICACHE_WORDS)-1:0] count_value;
	logic                             count_last;
	logic                             idle_ready;
	logic                             s2_valid;
	logic                             hit;
	logic                             beat_take;
	logic                             fill_write;
	logic                             respond;
	logic                             flush_clear;

	icache_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.flush       (flush),
		.s2_valid    (s2_valid),
		.hit         (hit),
		.count_last  (count_last),
		.wb_ack      (wb_ack),
		.idle_ready  (idle_ready),
		.count_op    (count_op),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.beat_take   (beat_take),
		.fill_write  (fill_write),
		.respond     (respond),
		.flush_clear (flush_clear)
	);

	icache_beat_counter u_counter (
		.clk         (clk),
		.reset       (reset),
		.count_op    (count_op),
		.count_value (count_value),
		.count_last  (count_last)
	);

	icache_dp u_dp (
		.clk         (clk),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_addr    (cpu_addr),
		.idle_ready  (idle_ready),
		.beat_take   (beat_take),
		.fill_write  (fill_write),
		.respond     (respond),
		.flush_clear (flush_clear),
		.count_value (count_value),
		.wb_dat_i    (wb_dat_i),
		.cpu_ready   (cpu_ready),
		.cpu_rvalid  (cpu_rvalid),
		.cpu_rdata   (cpu_rdata),
		.wb_adr      (wb_adr),
		.s2_valid    (s2_valid),
		.hit         (hit)
	);

endmodule

`default_nettype wire

//--- design/icache_way.sv
`default_nettype none

`include "icache_cfg.svh"

module icache_way (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [`ICACHE_INDEX_BITS-1:0]   rindex,
	input  logic [`ICACHE_INDEX_BITS-1:0]   windex,
	input  logic                            write,
	input  logic                            flush_clear,
	input  logic [`ICACHE_TAG_BITS-1:0]     tag_in,
	input  logic [`ICACHE_WORDS*32-1:0]     line_in,
	output logic [`ICACHE_TAG_BITS-1:0]     tag_out,
	output logic                            valid_out,
	output logic [`ICACHE_WORDS*32-1:0]     line_out
);
	localparam int SETS = 2 ** `ICACHE_INDEX_BITS;

	logic [`ICACHE_TAG_BITS-1:0] tags  [SETS];
	logic [`ICACHE_WORDS*32-1:0] lines [SETS];
	logic [SETS-1:0]             valid;

	// read side sees the old contents on a same-edge write
	always_ff @(posedge clk) begin
		if (write) begin
			tags[windex]  <= tag_in;
			lines[windex] <= line_in;
		end
		tag_out  <= tags[rindex];
		line_out <= lines[rindex];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid     <= '0;
			valid_out <= 1'b0;
		end else begin
			if (flush_clear) begin
				valid[windex] <= 1'b0;
			end else if (write) begin
				valid[windex] <= 1'b1;
			end
			valid_out <= valid[rindex];
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/icache_pkg.sv
design/icache_ctrl.sv
design/icache_beat_counter.sv
design/icache_way.sv
design/icache_dp.sv
design/icache_top.sv
verification/wb_mem_model.sv
verification/icache_tb.sv

//--- verification/icache_tb.sv
`default_nettype none

module icache_tb;
	localparam int          CLK_PERIOD    = 10;
	localparam int          FLUSH_CYCLES  = 8;
	localparam int          RANDOM_REQS   = 300;
	// cold miss, hit stream, lru and flush requests
	localparam int          DIRECTED_REQS = 17;
	localparam int          REQ_COUNT     = DIRECTED_REQS + RANDOM_REQS;
	localparam logic [31:0] DATA_KEY      = 32'h5A5A_0000;

	logic        clk = 1'b0;
	logic        reset;
	logic        flush;
	logic        cpu_req;
	logic [31:0] cpu_addr;
	logic        cpu_ready;
	logic        cpu_rvalid;
	logic [31:0] cpu_rdata;
	logic        wb_cyc;
	logic        wb_stb;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_i;
	logic        wb_ack;

	// requests in flight with the oldest first
	logic [31:0] pend_addr [$];
	int          pend_cycle [$];
	int          cycle = 0;
	int          max_latency = 0;
	int          bus_cycles = 0;
	int          beats = 0;
	int          cycle_beats = 0;
	logic        cyc_q = 1'b0;

	icache_top uut (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.cpu_req    (cpu_req),
		.cpu_addr   (cpu_addr),
		.wb_dat_i   (wb_dat_i),
		.wb_ack     (wb_ack),
		.cpu_ready  (cpu_ready),
		.cpu_rvalid (cpu_rvalid),
		.cpu_rdata  (cpu_rdata),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_adr     (wb_adr)
	);

	wb_mem_model mem (
		.clk    (clk),
		.reset  (reset),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_adr (wb_adr),
		.wb_dat (wb_dat_i),
		.wb_ack (wb_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ DATA_KEY;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
		end
	endtask

	// acceptance, response data and bus beat order as seen at the rising edge
	always @(posedge clk) begin : monitor
		int lat;
		cycle++;
		if (!reset) begin
			if (cpu_req && cpu_ready) begin
				pend_addr.push_back(cpu_addr);
				pend_cycle.push_back(cycle);
			end
			if (cpu_rvalid && pend_addr.size() == 0) begin
				abort_run("cpu_rvalid seen with no request outstanding");
			end else if (cpu_rvalid) begin
				check("cpu_rdata", cpu_rdata, mem_word(pend_addr[0]));
				lat = cycle - pend_cycle.pop_front();
				void'(pend_addr.pop_front());
				if (lat > max_latency) begin
					max_latency = lat;
				end
			end
			if (wb_cyc !== wb_stb) begin
				abort_run("wb_cyc and wb_stb do not move together");
			end
			if (wb_cyc && !cyc_q) begin
				bus_cycles++;
				cycle_beats = 0;
			end
			if (wb_cyc && wb_ack && pend_addr.size() == 0) begin
				abort_run("Wishbone beat with no missed request outstanding");
			end else if (wb_cyc && wb_ack) begin
				// beats climb from the line base in word steps
				check("wb_adr", wb_adr, {pend_addr[0][31:5], 5'b00000} + 32'(cycle_beats * 4));
				cycle_beats++;
				beats++;
			end
			if (!wb_cyc && cyc_q && cycle_beats != 8) begin
				abort_run("Wishbone cycle ended without eight beats");
			end
			cyc_q = wb_cyc;
		end
	end

	// hold one request until the cache takes it
	task automatic send(input logic [31:0] addr);
		int   waited;
		logic taken;
		waited   = 0;
		cpu_req  = 1'b1;
		cpu_addr = addr;
		do begin
			@(posedge clk);
			taken = cpu_ready;
			waited++;
			@(negedge clk);
			if (!taken && waited > 100) begin
				abort_run("request not accepted within 100 cycles");
			end
		end while (!taken);
	endtask

	task automatic drain();
		int waited;
		waited  = 0;
		cpu_req = 1'b0;
		while (pend_addr.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > 100) begin
				abort_run("no cpu_rvalid within 100 cycles");
			end
		end
	endtask

	task automatic access(input logic [31:0] addr, input int exp_cycles);
		int start;
		start = bus_cycles;
		send(addr);
		drain();
		check("bus cycles", bus_cycles - start, exp_cycles);
	endtask

	task automatic expect_flush_gap();
		int gap;
		gap = 0;
		while (!cpu_ready) begin
			@(negedge clk);
			gap++;
			if (gap > 3 * FLUSH_CYCLES) begin
				abort_run("cpu_ready stuck low after a flush");
			end
		end
		check("flush cycles", gap, FLUSH_CYCLES);
	endtask

	task automatic do_flush();
		flush = 1'b1;
		@(posedge clk);
		@(negedge clk);
		flush = 1'b0;
		expect_flush_gap();
	endtask

	task automatic after_reset();
		check("cpu_rvalid", cpu_rvalid, 0);
		check("wb_cyc", wb_cyc, 0);
		expect_flush_gap();
		repeat (5) begin
			@(negedge clk);
			check("cpu_ready", cpu_ready, 1);
		end
	endtask

	task automatic cold_miss();
		int b0;
		b0 = beats;
		access(32'h0000_106C, 1);
		check("beats", beats - b0, 8);
	endtask

	task automatic hit_stream();
		int start;
		int t0;
		start       = bus_cycles;
		t0          = cycle;
		max_latency = 0;
		for (int w = 0; w < 8; w++) begin
			send(32'h0000_1060 + 32'(w * 4));
		end
		drain();
		check("bus cycles", bus_cycles - start, 0);
		check("hit latency", max_latency, 1);
		// eight accepts in a row plus the last response
		check("hit stream cycles", cycle - t0, 9);
	endtask

	// tags 1, 2 and 3 share set 2
	task automatic lru_eviction();
		access(32'h0000_0144, 1);
		access(32'h0000_0248, 1);
		access(32'h0000_0144, 0);
		access(32'h0000_034C, 1);
		access(32'h0000_0144, 0);
		access(32'h0000_0248, 1);
	endtask

	task automatic flush_refetch();
		int b0;
		access(32'h0000_1070, 0);
		do_flush();
		b0 = beats;
		access(32'h0000_1070, 1);
		check("beats", beats - b0, 8);
	endtask

	task automatic random_stream();
		logic [23:0] tags [8][2];
		logic        valid [8][2];
		logic        lru [8];
		logic [23:0] tag;
		logic [2:0]  set;
		int          way;
		int          exp_cycles;
		int          start;
		do_flush();
		for (int s = 0; s < 8; s++) begin
			valid[s][0] = 1'b0;
			valid[s][1] = 1'b0;
			lru[s]      = 1'b0;
		end
		start      = bus_cycles;
		exp_cycles = 0;
		for (int n = 0; n < RANDOM_REQS; n++) begin
			tag = 24'($urandom % 4);
			set = 3'($urandom % 4);
			// reference cache where the lru bit names the way to replace
			if (valid[set][0] && tags[set][0] == tag) begin
				lru[set] = 1'b1;
			end else if (valid[set][1] && tags[set][1] == tag) begin
				lru[set] = 1'b0;
			end else begin
				way             = lru[set];
				tags[set][way]  = tag;
				valid[set][way] = 1'b1;
				lru[set]        = !lru[set];
				exp_cycles++;
			end
			send({tag, set, 3'($urandom % 8), 2'b00});
			if (($urandom % 4) == 0) begin
				cpu_req = 1'b0;
				@(negedge clk);
			end
		end
		drain();
		check("bus cycles", bus_cycles - start, exp_cycles);
	endtask

	initial begin
		#(REQ_COUNT * 100 * CLK_PERIOD);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(18916));
		reset    = 1'b1;
		flush    = 1'b0;
		cpu_req  = 1'b0;
		cpu_addr = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		after_reset();
		cold_miss();
		hit_stream();
		lru_eviction();
		flush_refetch();
		random_stream();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/wb_mem_model.sv
`default_nettype none

module wb_mem_model (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic [31:0] wb_adr,
	output logic [31:0] wb_dat,
	output logic        wb_ack
);
	localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;

	logic        busy;
	int unsigned wait_left;

	// one beat at a time with 0 to 3 extra wait cycles before the ack
	always @(posedge clk) begin
		if (reset) begin
			wb_ack    <= 1'b0;
			wb_dat    <= '0;
			busy      <= 1'b0;
			wait_left <= 0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			busy   <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!busy) begin
				busy      <= 1'b1;
				wait_left <= $urandom % 4;
			end else if (wait_left != 0) begin
				wait_left <= wait_left - 1;
			end else begin
				wb_ack <= 1'b1;
				wb_dat <= {wb_adr[31:2], 2'b00} ^ DATA_KEY;
			end
		end else begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire
